//--- hw/lcd_macros.svh
// PCD8544 panel and sprite constants
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

`define LCD_COLS            84
`define LCD_BANKS           6
`define LCD_BYTES           504
`define LCD_SCLK_HALF       2     // clock cycles per sclk half period
`define LCD_RESET_CYCLES    8

`define LCD_CMD_FUNC_EXT    8'h21 // extended instruction set
`define LCD_CMD_VOP         8'h90 // contrast
`define LCD_CMD_FUNC_BASIC  8'h20
`define LCD_CMD_DISP_NORMAL 8'h0C
`define LCD_CMD_SET_X       8'h80
`define LCD_CMD_SET_Y       8'h40

`define BAR_FULL_LEVEL      8
`define BAR_COLS            16
`define BAR_FILL            8'h7E
`define BAR0_X              9     // hunger
`define BAR0_BANK           0
`define BAR1_X              39    // sleep
`define BAR1_BANK           0
`define BAR2_X              66    // fun
`define BAR2_BANK           0
`define BAR3_X              21    // mood
`define BAR3_BANK           1
`define BAR4_X              60    // health
`define BAR4_BANK           1

`define FACE_X              37
`define FACE_BANK           3
`define FACE_COLS           4

`endif

//--- hw/lcd_pkg.sv
// Display controller types
`default_nettype none

package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [3:0] level_t;
	typedef logic [6:0] col_t;
	typedef logic [2:0] bank_t;

	// one byte to the panel with its data/command flag
	typedef struct packed {
		logic      dc;    // 1 = display data
		lcd_byte_t data;
	} lcd_word_t;

	typedef struct packed {
		level_t hunger;
		level_t sleep;
		level_t fun;
		level_t mood;
		level_t health;
	} pet_levels_t;

	typedef enum logic [1:0] {
		draw_bars,
		draw_face_happy,
		draw_face_neutral,
		draw_face_sad
	} draw_kind_e;

	typedef enum logic [2:0] {
		st_reset_hold,
		st_init_cmds,
		st_clear_addr,
		st_clear_fill,
		st_idle,
		st_bars,
		st_face
	} seq_state_e;

endpackage

`default_nettype wire

//--- hw/spi_byte_tx.sv
// SPI byte transmitter
`default_nettype none
`include "lcd_macros.svh"

module spi_byte_tx (
	input  logic               clock,
	input  logic               rst,
	input  lcd_pkg::lcd_word_t word,
	input  logic               start,
	output logic               mosi,
	output logic               sclk,
	output logic               sce,
	output logic               dc,
	output logic               avail
);

	logic               busy;
	logic               sclk_q;
	logic               dc_q;
	logic [7:0]         half_cnt;
	logic [2:0]         bit_cnt;
	logic               half_end;
	lcd_pkg::lcd_byte_t shreg;

	assign half_end = (half_cnt == 8'(`LCD_SCLK_HALF - 1));
	assign avail    = start & ~busy;   // latch only between bytes

	assign mosi = shreg[7];
	assign sclk = sclk_q;
	assign sce  = ~busy;
	assign dc   = dc_q;

	//--------------------------------------------------------------------------
	// frame control
	always_ff @(posedge clock) begin
		if (rst) begin
			busy     <= 1'b0;
			sclk_q   <= 1'b0;
			dc_q     <= 1'b0;
			half_cnt <= '0;
			bit_cnt  <= '0;
		end else if (!busy) begin
			half_cnt <= '0;
			bit_cnt  <= '0;
			sclk_q   <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				dc_q <= word.dc;   // held for the whole byte
			end
		end else if (half_end) begin
			half_cnt <= '0;
			sclk_q   <= ~sclk_q;
			if (sclk_q) begin
				if (bit_cnt == 3'd7)
					busy <= 1'b0;   // sce high for at least one cycle
				else
					bit_cnt <= bit_cnt + 3'd1;
			end
		end else begin
			half_cnt <= half_cnt + 8'd1;
		end
	end

	//--------------------------------------------------------------------------
	// shift register, msb first
	always_ff @(posedge clock) begin
		if (avail)
			shreg <= word.data;
		else if (busy && half_end && sclk_q)
			shreg <= {shreg[6:0], 1'b0};   // next bit on falling sclk
	end

endmodule

`default_nettype wire

//--- hw/bar_painter.sv
// Status bar sub-sequencer
`default_nettype none
`include "lcd_macros.svh"

module bar_painter (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 go,
	input  lcd_pkg::pet_levels_t levels,
	input  logic                 avail,
	output lcd_pkg::lcd_word_t   word,
	output logic                 finished
);

	lcd_pkg::level_t sat_q [5];
	logic            active;
	logic [2:0]      bar;
	logic [4:0]      step;       // 0 set y, 1 set x, then columns
	logic [4:0]      col_idx;
	logic            last_step;
	lcd_pkg::col_t   bar_x;
	lcd_pkg::bank_t  bar_bank;
	lcd_pkg::level_t cur_level;

	function automatic lcd_pkg::level_t saturate(input lcd_pkg::level_t lv);
		if (lv > 4'(`BAR_FULL_LEVEL))
			return 4'(`BAR_FULL_LEVEL);
		return lv;
	endfunction

	always_comb begin
		case (bar)
			3'd0: bar_x = 7'(`BAR0_X);
			3'd1: bar_x = 7'(`BAR1_X);
			3'd2: bar_x = 7'(`BAR2_X);
			3'd3: bar_x = 7'(`BAR3_X);
			default: bar_x = 7'(`BAR4_X);
		endcase
		case (bar)
			3'd0: bar_bank = 3'(`BAR0_BANK);
			3'd1: bar_bank = 3'(`BAR1_BANK);
			3'd2: bar_bank = 3'(`BAR2_BANK);
			3'd3: bar_bank = 3'(`BAR3_BANK);
			default: bar_bank = 3'(`BAR4_BANK);
		endcase
	end

	assign cur_level = sat_q[bar];
	assign col_idx   = step - 5'd2;
	assign last_step = (step == 5'(`BAR_COLS + 1));
	assign finished  = active & avail & last_step & (bar == 3'd4);

	always_comb begin
		word.dc   = (step > 5'd1);
		if (step == 5'd0)
			word.data = `LCD_CMD_SET_Y | {5'd0, bar_bank};
		else if (step == 5'd1)
			word.data = `LCD_CMD_SET_X | {1'b0, bar_x};
		else
			word.data = (col_idx < {cur_level, 1'b0}) ? `BAR_FILL : 8'h00;   // two cols per level
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			active <= 1'b0;
			bar    <= '0;
			step   <= '0;
		end else if (go) begin
			active <= 1'b1;
			bar    <= '0;
			step   <= '0;
		end else if (active && avail) begin
			if (last_step) begin
				step <= '0;
				if (bar == 3'd4)
					active <= 1'b0;
				else
					bar <= bar + 3'd1;
			end else begin
				step <= step + 5'd1;
			end
		end
	end

	// levels frozen for the whole drawing
	always_ff @(posedge clock) begin
		if (go) begin
			sat_q[0] <= saturate(levels.hunger);
			sat_q[1] <= saturate(levels.sleep);
			sat_q[2] <= saturate(levels.fun);
			sat_q[3] <= saturate(levels.mood);
			sat_q[4] <= saturate(levels.health);
		end
	end

endmodule

`default_nettype wire

//--- hw/face_painter.sv
// Face sprite sub-sequencer
`default_nettype none
`include "lcd_macros.svh"

module face_painter (
	input  logic                clock,
	input  logic                rst,
	input  logic                go,
	input  lcd_pkg::draw_kind_e kind,
	input  logic                avail,
	output lcd_pkg::lcd_word_t  word,
	output logic                finished
);

	logic                active;
	logic                row;        // 0 eyes, 1 mouth
	logic [2:0]          step;
	logic [1:0]          col;
	logic                last_step;
	lcd_pkg::draw_kind_e kind_q;

	function automatic lcd_pkg::lcd_byte_t face_byte(input logic bottom,
		input lcd_pkg::draw_kind_e k, input logic [1:0] c);
		logic [31:0] bits;
		if (!bottom)
			bits = 32'hDE08_08DE;
		else begin
			case (k)
				lcd_pkg::draw_face_happy: bits = 32'h1214_3452;
				lcd_pkg::draw_face_sad:   bits = 32'h1412_3254;
				default:                  bits = 32'h0012_3200;
			endcase
		end
		return bits[{~c, 3'b000} +: 8];   // leftmost column in the top byte
	endfunction

	assign col       = 2'(step - 3'd2);
	assign last_step = (step == 3'(`FACE_COLS + 1));
	assign finished  = active & avail & last_step & row;

	always_comb begin
		word.dc = (step > 3'd1);
		if (step == 3'd0)
			word.data = `LCD_CMD_SET_Y | {5'd0, 3'(`FACE_BANK) + {2'd0, row}};
		else if (step == 3'd1)
			word.data = `LCD_CMD_SET_X | 8'(`FACE_X);
		else
			word.data = face_byte(row, kind_q, col);
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			active <= 1'b0;
			row    <= 1'b0;
			step   <= '0;
		end else if (go) begin
			active <= 1'b1;
			row    <= 1'b0;
			step   <= '0;
		end else if (active && avail) begin
			if (last_step) begin
				step <= '0;
				if (row)
					active <= 1'b0;
				else
					row <= 1'b1;
			end else begin
				step <= step + 3'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (go)
			kind_q <= kind;
	end

endmodule

`default_nettype wire

//--- hw/screen_sequencer.sv
// Panel bring-up and draw dispatch
`default_nettype none
`include "lcd_macros.svh"

module screen_sequencer (
	input  logic                clock,
	input  logic                rst,
	input  logic                draw,
	input  lcd_pkg::draw_kind_e draw_kind,
	input  logic                avail,
	input  lcd_pkg::lcd_word_t  bar_word,
	input  logic                bar_finished,
	input  lcd_pkg::lcd_word_t  face_word,
	input  logic                face_finished,
	output lcd_pkg::lcd_word_t  word,
	output logic                start,
	output logic                bar_go,
	output logic                bar_avail,
	output logic                face_go,
	output logic                face_avail,
	output logic                lcd_reset_n,
	output logic                done
);

	lcd_pkg::seq_state_e state;
	logic [8:0]          cnt;      // reset hold, init index, clear bytes
	logic                accept;
	lcd_pkg::lcd_byte_t  init_cmd;

	assign accept     = draw & done;   // done is only high in idle
	assign bar_go     = accept & (draw_kind == lcd_pkg::draw_bars);
	assign face_go    = accept & (draw_kind != lcd_pkg::draw_bars);
	assign bar_avail  = avail & (state == lcd_pkg::st_bars);
	assign face_avail = avail & (state == lcd_pkg::st_face);
	assign start      = (state != lcd_pkg::st_reset_hold) && (state != lcd_pkg::st_idle);

	always_comb begin
		case (cnt[1:0])
			2'd0: init_cmd = `LCD_CMD_FUNC_EXT;
			2'd1: init_cmd = `LCD_CMD_VOP;
			2'd2: init_cmd = `LCD_CMD_FUNC_BASIC;
			default: init_cmd = `LCD_CMD_DISP_NORMAL;
		endcase
	end

	//--------------------------------------------------------------------------
	// word to the transmitter
	always_comb begin
		case (state)
			lcd_pkg::st_init_cmds: word = {1'b0, init_cmd};
			lcd_pkg::st_clear_addr: word = {1'b0, cnt[0] ? `LCD_CMD_SET_X : `LCD_CMD_SET_Y};
			lcd_pkg::st_clear_fill: word = {1'b1, 8'h00};
			lcd_pkg::st_bars: word = bar_word;
			lcd_pkg::st_face: word = face_word;
			default: word = '0;
		endcase
	end

	//--------------------------------------------------------------------------
	// main FSM
	always_ff @(posedge clock) begin
		if (rst) begin
			state       <= lcd_pkg::st_reset_hold;
			cnt         <= '0;
			lcd_reset_n <= 1'b0;
			done        <= 1'b0;
		end else begin
			case (state)
				lcd_pkg::st_reset_hold: begin
					if (cnt == 9'(`LCD_RESET_CYCLES - 1)) begin
						state       <= lcd_pkg::st_init_cmds;
						cnt         <= '0;
						lcd_reset_n <= 1'b1;
					end else begin
						cnt <= cnt + 9'd1;
					end
				end
				lcd_pkg::st_init_cmds: begin
					if (avail) begin
						if (cnt == 9'd3) begin
							state <= lcd_pkg::st_clear_addr;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 9'd1;
						end
					end
				end
				lcd_pkg::st_clear_addr: begin
					if (avail) begin
						if (cnt[0]) begin
							state <= lcd_pkg::st_clear_fill;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 9'd1;
						end
					end
				end
				lcd_pkg::st_clear_fill: begin
					if (avail) begin
						if (cnt == 9'(`LCD_BYTES - 1)) begin
							state <= lcd_pkg::st_idle;
							done  <= 1'b1;
						end else begin
							cnt <= cnt + 9'd1;
						end
					end
				end
				lcd_pkg::st_idle: begin
					if (accept) begin
						done  <= 1'b0;
						state <= bar_go ? lcd_pkg::st_bars : lcd_pkg::st_face;
					end
				end
				lcd_pkg::st_bars: begin
					if (bar_finished) begin
						state <= lcd_pkg::st_idle;
						done  <= 1'b1;
					end
				end
				lcd_pkg::st_face: begin
					if (face_finished) begin
						state <= lcd_pkg::st_idle;
						done  <= 1'b1;
					end
				end
				default: state <= lcd_pkg::st_reset_hold;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/pet_display_top.sv
// Virtual pet display controller
`default_nettype none

module pet_display_top (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 draw,
	input  lcd_pkg::draw_kind_e  draw_kind,
	input  lcd_pkg::pet_levels_t levels,
	output logic                 mosi,
	output logic                 sclk,
	output logic                 sce,
	output logic                 dc,
	output logic                 lcd_reset_n,
	output logic                 done
);

	lcd_pkg::lcd_word_t seq_word;
	lcd_pkg::lcd_word_t bar_word;
	lcd_pkg::lcd_word_t face_word;
	logic               start;
	logic               avail;
	logic               bar_go;
	logic               bar_avail;
	logic               bar_finished;
	logic               face_go;
	logic               face_avail;
	logic               face_finished;

	screen_sequencer u_seq (
		.clock         (clock),
		.rst           (rst),
		.draw          (draw),
		.draw_kind     (draw_kind),
		.avail         (avail),
		.bar_word      (bar_word),
		.bar_finished  (bar_finished),
		.face_word     (face_word),
		.face_finished (face_finished),
		.word          (seq_word),
		.start         (start),
		.bar_go        (bar_go),
		.bar_avail     (bar_avail),
		.face_go       (face_go),
		.face_avail    (face_avail),
		.lcd_reset_n   (lcd_reset_n),
		.done          (done)
	);

	bar_painter u_bars (
		.clock    (clock),
		.rst      (rst),
		.go       (bar_go),
		.levels   (levels),
		.avail    (bar_avail),
		.word     (bar_word),
		.finished (bar_finished)
	);

	face_painter u_face (
		.clock    (clock),
		.rst      (rst),
		.go       (face_go),
		.kind     (draw_kind),
		.avail    (face_avail),
		.word     (face_word),
		.finished (face_finished)
	);

	spi_byte_tx u_spi (
		.clock (clock),
		.rst   (rst),
		.word  (seq_word),
		.start (start),
		.mosi  (mosi),
		.sclk  (sclk),
		.sce   (sce),
		.dc    (dc),
		.avail (avail)
	);

endmodule

`default_nettype wire

//--- verification/pet_display_assertions.sv
// SPI and control timing checks
`default_nettype none

module pet_display_assertions (
	input logic clock,
	input logic rst,
	input logic sce,
	input logic sclk,
	input logic lcd_reset_n,
	input logic start,
	input logic avail,
	input logic draw,
	input logic done
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	a_reset_quiet: assert property (@(posedge clock) disable iff (rst)
		!lcd_reset_n |-> (sce && !start))
		else begin
			fail_count++;
			$error("SPI activity while the panel is held in reset");
		end

	a_sclk_idle: assert property (@(posedge clock) disable iff (rst)
		sce |-> !sclk)
		else begin
			fail_count++;
			$error("sclk high while chip select is released");
		end

	a_avail_single: assert property (@(posedge clock) disable iff (rst)
		avail |=> !avail)
		else begin
			fail_count++;
			$error("avail high for two cycles in a row");
		end

	a_done_falls: assert property (@(posedge clock) disable iff (rst)
		(draw && done) |=> !done)
		else begin
			fail_count++;
			$error("done still high after an accepted draw");
		end

endmodule

bind pet_display_top pet_display_assertions u_timing_checks (
	.clock       (clock),
	.rst         (rst),
	.sce         (sce),
	.sclk        (sclk),
	.lcd_reset_n (lcd_reset_n),
	.start       (start),
	.avail       (avail),
	.draw        (draw),
	.done        (done)
);

`default_nettype wire

//--- verification/pet_display_tb.sv
// Pet display testbench
`default_nettype none
`include "lcd_macros.svh"

module pet_display_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BAR_DRAW_BYTES  = 5 * (2 + `BAR_COLS);
	localparam int FACE_DRAW_BYTES = 2 * (2 + `FACE_COLS);
	localparam int MAX_CYCLES      = 80000;   // ~1400 bytes at 33 cycles, with margin

	localparam int BAR_X [5]    = '{`BAR0_X, `BAR1_X, `BAR2_X, `BAR3_X, `BAR4_X};
	localparam int BAR_BANK [5] = '{`BAR0_BANK, `BAR1_BANK, `BAR2_BANK, `BAR3_BANK, `BAR4_BANK};
	localparam logic [7:0] INIT_CMDS [4] = '{`LCD_CMD_FUNC_EXT, `LCD_CMD_VOP,
		`LCD_CMD_FUNC_BASIC, `LCD_CMD_DISP_NORMAL};
	localparam logic [7:0] FACE_TOP [4]     = '{8'hDE, 8'h08, 8'h08, 8'hDE};
	localparam logic [7:0] FACE_HAPPY [4]   = '{8'h12, 8'h14, 8'h34, 8'h52};
	localparam logic [7:0] FACE_NEUTRAL [4] = '{8'h00, 8'h12, 8'h32, 8'h00};
	localparam logic [7:0] FACE_SAD [4]     = '{8'h14, 8'h12, 8'h32, 8'h54};

	logic                 clock;
	logic                 rst;
	logic                 draw;
	lcd_pkg::draw_kind_e  draw_kind;
	lcd_pkg::pet_levels_t levels;
	logic                 mosi;
	logic                 sclk;
	logic                 sce;
	logic                 dc;
	logic                 lcd_reset_n;
	logic                 done;

	logic [31:0]        rng;
	lcd_pkg::lcd_word_t byte_log [$];   // dc and data, in order
	lcd_pkg::lcd_byte_t fb_model [`LCD_BYTES];
	lcd_pkg::lcd_byte_t fb_expect [`LCD_BYTES];
	int                 mx;
	int                 my;
	int                 bit_cnt;
	logic               sclk_prev;
	lcd_pkg::lcd_byte_t shift;
	logic               reset_low_seen;
	int                 bytes_total;
	int                 data_count;
	int                 errors;
	int                 tests;
	int                 tests_failed;
	int                 cycles;

	pet_display_top u_dut (
		.clock       (clock),
		.rst         (rst),
		.draw        (draw),
		.draw_kind   (draw_kind),
		.levels      (levels),
		.mosi        (mosi),
		.sclk        (sclk),
		.sce         (sce),
		.dc          (dc),
		.lcd_reset_n (lcd_reset_n),
		.done        (done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not complete within %0d clock cycles", MAX_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//--------------------------------------------------------------------------
	// helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng = lcg_next(rng);
		r = rng;
	endtask

	task automatic report_error(input string msg);
		$display("error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests++;
		if (errors == err_start) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", tests, name, errors - err_start);
		end
	endtask

	function automatic int level_of(input lcd_pkg::pet_levels_t lv, input int b);
		case (b)
			0: return int'(lv.hunger);
			1: return int'(lv.sleep);
			2: return int'(lv.fun);
			3: return int'(lv.mood);
			default: return int'(lv.health);
		endcase
	endfunction

	task automatic apply_bars(input lcd_pkg::pet_levels_t lv);
		int lev;
		int base;
		for (int b = 0; b < 5; b++) begin
			lev = level_of(lv, b);
			if (lev > `BAR_FULL_LEVEL)
				lev = `BAR_FULL_LEVEL;   // saturate
			base = BAR_BANK[b] * `LCD_COLS + BAR_X[b];
			for (int c = 0; c < `BAR_COLS; c++)
				fb_expect[base + c] = (c < 2 * lev) ? `BAR_FILL : 8'h00;
		end
	endtask

	task automatic apply_face(input lcd_pkg::draw_kind_e kind);
		int top;
		top = `FACE_BANK * `LCD_COLS + `FACE_X;
		for (int c = 0; c < `FACE_COLS; c++) begin
			fb_expect[top + c] = FACE_TOP[c];
			case (kind)
				lcd_pkg::draw_face_happy: fb_expect[top + `LCD_COLS + c] = FACE_HAPPY[c];
				lcd_pkg::draw_face_sad:   fb_expect[top + `LCD_COLS + c] = FACE_SAD[c];
				default:                  fb_expect[top + `LCD_COLS + c] = FACE_NEUTRAL[c];
			endcase
		end
	endtask

	task automatic compare_frame(input string what);
		int bad;
		int first;
		bad = 0;
		first = -1;
		for (int i = 0; i < `LCD_BYTES; i++) begin
			if (fb_model[i] !== fb_expect[i]) begin
				if (first < 0)
					first = i;
				bad++;
			end
		end
		assert (bad == 0) else report_error($sformatf(
			"%s: %0d bytes differ, first at bank %0d col %0d: got %02h expected %02h",
			what, bad, first / `LCD_COLS, first % `LCD_COLS, fb_model[first], fb_expect[first]));
	endtask

	//--------------------------------------------------------------------------
	// SPI decoder and panel model

	task automatic apply_byte(input logic d, input lcd_pkg::lcd_byte_t b);
		byte_log.push_back({d, b});
		bytes_total++;
		if (d) begin
			data_count++;
			if (mx < `LCD_COLS && my < `LCD_BANKS)
				fb_model[my * `LCD_COLS + mx] = b;
			mx++;
			if (mx >= `LCD_COLS) begin
				mx = 0;
				my = (my + 1) % `LCD_BANKS;   // wrap into next bank
			end
		end else if (b[7]) begin
			mx = int'(b[6:0]);
		end else if (b[7:6] == 2'b01) begin
			my = int'(b[2:0]);
		end
	endtask

	// sampled mid-cycle, where every DUT output is settled
	always @(negedge clock) begin
		if (rst) begin
			bit_cnt = 0;
			sclk_prev = 1'b0;
		end else begin
			if (!lcd_reset_n && byte_log.size() == 0)
				reset_low_seen = 1'b1;
			if (sce) begin
				bit_cnt = 0;
			end else if (sclk && !sclk_prev) begin
				shift = {shift[6:0], mosi};
				bit_cnt++;
				if (bit_cnt == 8) begin
					apply_byte(dc, shift);
					bit_cnt = 0;
				end
			end
			sclk_prev = sclk;
		end
	end

	//--------------------------------------------------------------------------
	// stimulus

	task automatic strobe_draw(input lcd_pkg::draw_kind_e kind, input lcd_pkg::pet_levels_t lv);
		@(posedge clock);
		#1;
		draw = 1'b1;
		draw_kind = kind;
		levels = lv;
		@(posedge clock);
		#1;
		draw = 1'b0;
	endtask

	task automatic wait_done();
		do
			@(negedge clock);
		while (!done);
	endtask

	// the last byte is still on the wire when done rises
	task automatic wait_line_idle();
		int quiet;
		quiet = 0;
		while (quiet < 4) begin
			@(negedge clock);
			if (sce)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic run_drawing(input lcd_pkg::draw_kind_e kind, input lcd_pkg::pet_levels_t lv);
		logic [31:0] r;
		int          base;
		int          expected;
		next_random(r);
		repeat (int'(r[31:29])) @(posedge clock);   // idle gap
		base = bytes_total;
		strobe_draw(kind, lv);
		wait_done();
		wait_line_idle();
		if (kind == lcd_pkg::draw_bars) begin
			apply_bars(lv);
			expected = BAR_DRAW_BYTES;
		end else begin
			apply_face(kind);
			expected = FACE_DRAW_BYTES;
		end
		assert (bytes_total - base == expected) else report_error($sformatf(
			"%s drawing sent %0d bytes, expected %0d", kind.name(), bytes_total - base, expected));
		compare_frame(kind.name());
	endtask

	initial begin
		logic [31:0]          r;
		lcd_pkg::pet_levels_t lv;
		lcd_pkg::draw_kind_e  kind;
		int                   err_start;
		int                   base;
		int                   stray;
		int                   assert_fails;

		rst = 1'b1;
		draw = 1'b0;
		draw_kind = lcd_pkg::draw_bars;
		levels = '0;
		rng = 32'h8f2e;
		mx = 0;
		my = 0;
		reset_low_seen = 1'b0;
		bytes_total = 0;
		data_count = 0;
		errors = 0;
		tests = 0;
		tests_failed = 0;
		for (int i = 0; i < `LCD_BYTES; i++) begin
			fb_model[i] = 8'(i ^ (i >> 3)) ^ 8'h5A;
			fb_expect[i] = 8'h00;   // blank after clear
		end
		repeat (5) @(posedge clock);
		#1;
		rst = 1'b0;

		err_start = errors;
		while (byte_log.size() < 4)
			@(negedge clock);
		assert (reset_low_seen) else report_error("panel reset never seen low before first byte");
		for (int i = 0; i < 4; i++)
			assert (byte_log[i] == {1'b0, INIT_CMDS[i]}) else report_error($sformatf(
				"init byte %0d is %03h, expected %03h", i, byte_log[i], {1'b0, INIT_CMDS[i]}));
		finish_test("init commands", err_start);

		err_start = errors;
		wait_done();
		wait_line_idle();
		assert (data_count == `LCD_BYTES) else report_error($sformatf(
			"clear wrote %0d data bytes, expected %0d", data_count, `LCD_BYTES));
		compare_frame("clear");
		finish_test("clear", err_start);

		err_start = errors;
		for (int n = 0; n < 8; n++) begin
			next_random(r);
			run_drawing(lcd_pkg::draw_bars, lcd_pkg::pet_levels_t'(r[31:12]));
		end
		finish_test("bar drawings", err_start);

		err_start = errors;
		for (int n = 0; n < 6; n++) begin
			next_random(r);
			case (int'(r[31:16]) % 3)
				0: kind = lcd_pkg::draw_face_happy;
				1: kind = lcd_pkg::draw_face_neutral;
				default: kind = lcd_pkg::draw_face_sad;
			endcase
			run_drawing(kind, levels);
		end
		finish_test("face drawings", err_start);

		// a second strobe while busy must vanish
		err_start = errors;
		next_random(r);
		lv = lcd_pkg::pet_levels_t'(r[31:12]);
		base = bytes_total;
		strobe_draw(lcd_pkg::draw_bars, lv);
		repeat (3) @(posedge clock);
		#1;
		assert (!done) else report_error("done high during a drawing");
		strobe_draw(lcd_pkg::draw_face_sad, ~lv);
		wait_done();
		assert (bytes_total - base >= BAR_DRAW_BYTES - 1) else report_error($sformatf(
			"done rose after only %0d bytes of the drawing", bytes_total - base));
		wait_line_idle();
		stray = 0;
		repeat (64) begin
			@(negedge clock);
			if (!done || !sce)
				stray++;
		end
		assert (stray == 0) else report_error("a second drawing started after the ignored strobe");
		apply_bars(lv);
		assert (bytes_total - base == BAR_DRAW_BYTES) else report_error($sformatf(
			"drawing with ignored strobe sent %0d bytes, expected %0d",
			bytes_total - base, BAR_DRAW_BYTES));
		compare_frame("ignored strobe");
		finish_test("ignored strobe", err_start);

		assert_fails = u_dut.u_timing_checks.fail_count;
		$display("tests run %0d, failed %0d, errors %0d, timing assertion failures %0d",
			tests, tests_failed, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/lcd_pkg.sv
hw/spi_byte_tx.sv
hw/bar_painter.sv
hw/face_painter.sv
hw/screen_sequencer.sv
hw/pet_display_top.sv
verification/pet_display_assertions.sv
verification/pet_display_tb.sv

//--- Makefile
TOP = pet_display_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
